/* verif/core_ctrl_patterns.txt */
// Columns: op_addr_data_expect in hex, one record per line, op ff ends the list
// Ops: 01 write, 02 read, 03 bus, 04 enable (addr pwr:lc, data fatal), 05 push, 06 watchdog
01_00000008_100007ff_00000000
01_00000009_20000000_00000000
01_0000000a_10007fff_00000000
01_0000000b_30000000_00000000
01_00000000_00000003_00000000
02_00000008_00000000_100007ff
02_0000000b_00000000_30000000
02_00000000_00000000_00000003
02_0000000c_00000000_00000000
03_10000123_00000000_20000123
03_10008456_00000000_30008456
03_40000010_00000000_40000010
01_00000000_00000001_00000000
03_10008456_00000000_10008456
04_000000aa_00000000_00000001
04_000000a3_00000000_00000000
04_000000aa_00000000_00000001
04_0000005a_00000000_00000000
04_000000aa_00000000_00000001
04_000000aa_00000001_00000000
04_000000aa_00000000_00000000
06_00000000_00000000_00000000
02_00000002_00000000_00000001
01_00000001_00000001_00000001
01_00000002_00000001_00000000
02_00000002_00000000_00000000
05_00000001_3c96a5e1_00000000
02_00000004_00000000_00000001
05_00000000_0f1e2d3c_00000000
02_00000003_00000000_3c96a5e1
02_00000004_00000000_00000000
05_00000001_77665544_00000000
ff_00000000_00000000_00000000

/* sources.f */
src/core_ctrl_pkg.sv
src/cfg_regs.sv
src/addr_remap.sv
src/fetch_gate.sv
src/rnd_buffer.sv
src/core_ctrl_top.sv
verif/core_ctrl_properties.sv
verif/core_ctrl_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := core_ctrl_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/core_ctrl_tb.sv */
//////////////////////////////////////////////////////////////////////
// Record-driven testbench for core_ctrl_top with two remap regions.
// Must run from the project root so that the pattern file is found.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module core_ctrl_tb
  import core_ctrl_pkg::*;
();

  localparam int NumRegions = 2;
  localparam int MaxRecords = 64;

  // Operation codes of the pattern records
  localparam logic [7:0] OpWrite  = 8'h01;
  localparam logic [7:0] OpRead   = 8'h02;
  localparam logic [7:0] OpBus    = 8'h03;
  localparam logic [7:0] OpEnable = 8'h04;
  localparam logic [7:0] OpPush   = 8'h05;
  localparam logic [7:0] OpWdog   = 8'h06;
  localparam logic [7:0] OpEnd    = 8'hff;

  logic         clk;
  logic         rst_n;
  logic         cfg_valid;
  logic         cfg_we;
  cfg_addr_t    cfg_addr;
  data_t        cfg_wdata;
  logic         cfg_rvalid;
  data_t        cfg_rdata;
  logic         nmi_wdog;
  logic         irq_nm;
  logic         core_valid;
  addr_t        core_addr;
  logic         core_ready;
  logic         mem_valid;
  addr_t        mem_addr;
  logic         mem_ready;
  lc_tx_t       lc_cpu_en;
  lc_tx_t       pwr_cpu_en;
  logic         fatal_core_err;
  logic         fetch_enable;
  logic         ent_valid;
  data_t        ent_data;
  logic         ent_ready;

  logic [103:0] patterns [MaxRecords];
  logic [7:0]   rec_op;
  data_t        rec_addr;
  data_t        rec_data;
  data_t        rec_exp;
  logic         fetch_prev;
  int           num_records;
  int           cycle_limit = 1000;
  int           cycles = 0;
  int           checks = 0;
  int           errors = 0;
  int           seed;

  core_ctrl_top #(
    .NumRegions (NumRegions)
  ) i_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .cfg_valid_i      (cfg_valid),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .cfg_rvalid_o     (cfg_rvalid),
    .cfg_rdata_o      (cfg_rdata),
    .nmi_wdog_i       (nmi_wdog),
    .irq_nm_o         (irq_nm),
    .dbus_valid_i     (core_valid),
    .dbus_addr_i      (core_addr),
    .dbus_ready_o     (core_ready),
    .dbus_valid_o     (mem_valid),
    .dbus_addr_o      (mem_addr),
    .dbus_ready_i     (mem_ready),
    .lc_cpu_en_i      (lc_cpu_en),
    .pwr_cpu_en_i     (pwr_cpu_en),
    .fatal_core_err_i (fatal_core_err),
    .fetch_enable_o   (fetch_enable),
    .ent_valid_i      (ent_valid),
    .ent_data_i       (ent_data),
    .ent_ready_o      (ent_ready)
  );

  bind core_ctrl_top core_ctrl_properties i_properties (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fatal_core_err_i (fatal_core_err_i),
    .fetch_enable_i   (fetch_enable_o),
    .core_valid_i     (dbus_valid_i),
    .core_ready_i     (dbus_ready_o),
    .mem_valid_i      (dbus_valid_o),
    .mem_ready_i      (dbus_ready_i),
    .ent_ready_i      (ent_ready_o),
    .rnd_valid_i      (rnd_valid)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: no result after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input data_t actual, input data_t expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL %0t %s: got %b, expected %b", $time, name, actual, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Record operations, each one ends just after a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic load_patterns();
    $readmemh("verif/core_ctrl_patterns.txt", patterns);
    num_records = 0;
    while (num_records < MaxRecords && patterns[num_records][103:96] !== OpEnd) begin
      num_records++;
    end
    if (num_records == 0) begin
      errors++;
      $display("No records found in the pattern file");
    end
  endtask

  task automatic write_reg(input data_t addr, input data_t data, input logic irq_exp);
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_we    <= 1'b1;
    cfg_addr  <= addr[3:0];
    cfg_wdata <= data;
    @(posedge clk);
    cfg_valid <= 1'b0;
    cfg_we    <= 1'b0;
    @(negedge clk);
    check_bit("irq_nm_o", irq_nm, irq_exp);
  endtask

  // Response comes exactly one cycle after the sampling edge
  task automatic read_reg(input data_t addr, input data_t rdata_exp);
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_we    <= 1'b0;
    cfg_addr  <= addr[3:0];
    @(posedge clk);
    cfg_valid <= 1'b0;
    @(negedge clk);
    check_bit("cfg_rvalid_o", cfg_rvalid, 1'b1);
    check_word("cfg_rdata_o", cfg_rdata, rdata_exp);
    @(negedge clk);
    check_bit("cfg_rvalid_o", cfg_rvalid, 1'b0);
  endtask

  task automatic bus_access(input addr_t addr, input addr_t addr_exp);
    int   rnd;
    logic ready_bit;
    rnd = $random(seed);
    ready_bit = rnd[0];
    @(posedge clk);
    core_valid <= 1'b1;
    core_addr  <= addr;
    mem_ready  <= ready_bit;
    @(negedge clk);
    check_word("dbus_addr_o", mem_addr, addr_exp);
    check_bit("dbus_valid_o", mem_valid, 1'b1);
    check_bit("dbus_ready_o", core_ready, ready_bit);
    @(posedge clk);
    core_valid <= 1'b0;
    @(negedge clk);
    check_bit("dbus_valid_o", mem_valid, 1'b0);
  endtask

  // Codes hold pwr in bits 7:4 and lc in bits 3:0
  task automatic set_enables(input logic [7:0] codes, input logic fatal, input logic fetch_exp);
    @(posedge clk);
    lc_cpu_en      <= codes[3:0];
    pwr_cpu_en     <= codes[7:4];
    fatal_core_err <= fatal;
    @(posedge clk);
    fatal_core_err <= 1'b0;
    @(negedge clk);
    if (fatal) begin
      check_bit("fetch_enable_o", fetch_enable, fetch_exp);
    end else begin
      // Old value holds until the second edge
      check_bit("fetch_enable_o", fetch_enable, fetch_prev);
      @(negedge clk);
      check_bit("fetch_enable_o", fetch_enable, fetch_exp);
    end
    fetch_prev = fetch_exp;
  endtask

  task automatic push_entropy(input logic ready_before, input data_t word,
                              input logic ready_after);
    check_bit("ent_ready_o", ent_ready, ready_before);
    @(posedge clk);
    ent_valid <= 1'b1;
    ent_data  <= word;
    @(posedge clk);
    ent_valid <= 1'b0;
    @(negedge clk);
    check_bit("ent_ready_o", ent_ready, ready_after);
  endtask

  // Two sync flops and the state flop, then one cycle of margin
  task automatic pulse_wdog(input logic irq_exp);
    @(posedge clk);
    nmi_wdog <= 1'b1;
    @(posedge clk);
    nmi_wdog <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_bit("irq_nm_o", irq_nm, irq_exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n          <= 1'b0;
    cfg_valid      <= 1'b0;
    cfg_we         <= 1'b0;
    cfg_addr       <= '0;
    cfg_wdata      <= '0;
    nmi_wdog       <= 1'b0;
    core_valid     <= 1'b0;
    core_addr      <= '0;
    mem_ready      <= 1'b0;
    lc_cpu_en      <= LcOff;
    pwr_cpu_en     <= LcOff;
    fatal_core_err <= 1'b0;
    ent_valid      <= 1'b0;
    ent_data       <= '0;
    seed = 32'h60ed_1027;
    fetch_prev = 1'b0;
    load_patterns();
    cycle_limit = num_records * 8 + 100;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("fetch_enable_o", fetch_enable, 1'b0);
    check_bit("irq_nm_o", irq_nm, 1'b0);
    check_bit("cfg_rvalid_o", cfg_rvalid, 1'b0);
    check_bit("dbus_valid_o", mem_valid, 1'b0);
    check_bit("ent_ready_o", ent_ready, 1'b1);

    for (int r = 0; r < num_records; r++) begin
      rec_op   = patterns[r][103:96];
      rec_addr = patterns[r][95:64];
      rec_data = patterns[r][63:32];
      rec_exp  = patterns[r][31:0];
      case (rec_op)
        OpWrite:  write_reg(rec_addr, rec_data, rec_exp[0]);
        OpRead:   read_reg(rec_addr, rec_exp);
        OpBus:    bus_access(rec_addr, rec_exp);
        OpEnable: set_enables(rec_addr[7:0], rec_data[0], rec_exp[0]);
        OpPush:   push_entropy(rec_addr[0], rec_data, rec_exp[0]);
        OpWdog:   pulse_wdog(rec_exp[0]);
        default: begin
          errors++;
          $display("Record %0d has an unknown operation code %h", r, rec_op);
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, i_dut.i_properties.fail_count);
    if (errors == 0 && i_dut.i_properties.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/core_ctrl_properties.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks on core_ctrl_top, bound from the testbench.
// Sampled on the rising clock and idle while reset is asserted.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module core_ctrl_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic fatal_core_err_i,
  input logic fetch_enable_i,
  // Data bus, core and memory side
  input logic core_valid_i,
  input logic core_ready_i,
  input logic mem_valid_i,
  input logic mem_ready_i,
  // Entropy buffer
  input logic ent_ready_i,
  input logic rnd_valid_i
);

  int fail_count = 0;

  // Local disable acts on the edge that samples the error
  a_fatal_disable: assert property (
    @(posedge clk_i) disable iff (!rst_ni) fatal_core_err_i |=> !fetch_enable_i
  ) else begin
    fail_count++;
    $error("fetch enable high in the cycle after a fatal core error");
  end

  // Handshake passes straight through
  a_dbus_pass: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (mem_valid_i == core_valid_i) && (core_ready_i == mem_ready_i)
  ) else begin
    fail_count++;
    $error("data bus valid or ready differs between core and memory side");
  end

  // Full buffer takes no new word
  a_ent_ready: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rnd_valid_i |-> !ent_ready_i
  ) else begin
    fail_count++;
    $error("entropy ready high while the random word is valid");
  end

endmodule

`default_nettype wire

/* src/core_ctrl_top.sv */
//////////////////////////////////////////////////////////////////////
// Control logic around the processor core, without the core itself.
// NumRegions may be 1 to 4 so the region words fit the register map.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module core_ctrl_top
  import core_ctrl_pkg::*;
#(
  parameter int NumRegions = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Register port
  input  logic      cfg_valid_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output logic      cfg_rvalid_o,
  output data_t     cfg_rdata_o,
  // Watchdog NMI
  input  logic      nmi_wdog_i,
  output logic      irq_nm_o,
  // Data bus, core side
  input  logic      dbus_valid_i,
  input  addr_t     dbus_addr_i,
  output logic      dbus_ready_o,
  // Data bus, memory side
  output logic      dbus_valid_o,
  output addr_t     dbus_addr_o,
  input  logic      dbus_ready_i,
  // Fetch enable control
  input  lc_tx_t    lc_cpu_en_i,
  input  lc_tx_t    pwr_cpu_en_i,
  input  logic      fatal_core_err_i,
  output logic      fetch_enable_o,
  // Entropy source
  input  logic      ent_valid_i,
  input  data_t     ent_data_i,
  output logic      ent_ready_o
);

  logic [NumRegions-1:0]  region_en;
  addr_t [NumRegions-1:0] region_match;
  addr_t [NumRegions-1:0] region_remap;
  data_t                  rnd_data;
  logic                   rnd_valid;
  logic                   rnd_rd;

  cfg_regs #(
    .NumRegions (NumRegions)
  ) i_cfg_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_valid_i    (cfg_valid_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_addr_i     (cfg_addr_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rvalid_o   (cfg_rvalid_o),
    .cfg_rdata_o    (cfg_rdata_o),
    .nmi_wdog_i     (nmi_wdog_i),
    .irq_nm_o       (irq_nm_o),
    .region_en_o    (region_en),
    .region_match_o (region_match),
    .region_remap_o (region_remap),
    .rnd_data_i     (rnd_data),
    .rnd_valid_i    (rnd_valid),
    .rnd_rd_o       (rnd_rd)
  );

  addr_remap #(
    .NumRegions (NumRegions)
  ) i_addr_remap (
    .dbus_valid_i   (dbus_valid_i),
    .dbus_addr_i    (dbus_addr_i),
    .dbus_ready_o   (dbus_ready_o),
    .dbus_valid_o   (dbus_valid_o),
    .dbus_addr_o    (dbus_addr_o),
    .dbus_ready_i   (dbus_ready_i),
    .region_en_i    (region_en),
    .region_match_i (region_match),
    .region_remap_i (region_remap)
  );

  fetch_gate i_fetch_gate (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lc_cpu_en_i      (lc_cpu_en_i),
    .pwr_cpu_en_i     (pwr_cpu_en_i),
    .fatal_core_err_i (fatal_core_err_i),
    .fetch_enable_o   (fetch_enable_o)
  );

  rnd_buffer i_rnd_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ent_valid_i (ent_valid_i),
    .ent_data_i  (ent_data_i),
    .ent_ready_o (ent_ready_o),
    .rnd_rd_i    (rnd_rd),
    .rnd_data_o  (rnd_data),
    .rnd_valid_o (rnd_valid)
  );

endmodule

`default_nettype wire

/* src/rnd_buffer.sv */
//////////////////////////////////////////////////////////////////////
// Single random word from the entropy source. Requests only while
// empty, a read pulse wins over a capture in the same cycle.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rnd_buffer
  import core_ctrl_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // Entropy source
  input  logic  ent_valid_i,
  input  data_t ent_data_i,
  output logic  ent_ready_o,
  // Register side
  input  logic  rnd_rd_i,
  output data_t rnd_data_o,
  output logic  rnd_valid_o
);

  data_t rnd_data_q;
  logic  rnd_valid_q;

  assign ent_ready_o = ~rnd_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_valid_q <= 1'b0;
      rnd_data_q  <= '0;
    end else if (rnd_rd_i) begin
      // Word is consumed, so it is wiped
      rnd_valid_q <= 1'b0;
      rnd_data_q  <= '0;
    end else if (ent_valid_i && ent_ready_o) begin
      rnd_valid_q <= 1'b1;
      rnd_data_q  <= ent_data_i;
    end
  end

  assign rnd_data_o  = rnd_data_q;
  assign rnd_valid_o = rnd_valid_q;

endmodule

`default_nettype wire

/* src/fetch_gate.sv */
//////////////////////////////////////////////////////////////////////
// Fetch enable from two multibit enables plus a local disable. Any
// code other than LcOn is off. A fatal error disables until reset.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_gate
  import core_ctrl_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  lc_tx_t lc_cpu_en_i,
  input  lc_tx_t pwr_cpu_en_i,
  input  logic   fatal_core_err_i,
  output logic   fetch_enable_o
);

  lc_tx_t lc_sync1_q;
  lc_tx_t lc_sync2_q;
  lc_tx_t pwr_sync1_q;
  lc_tx_t pwr_sync2_q;
  lc_tx_t local_en_q;

  //////////////////////////////////////////////////////////////////////
  // Enable synchronizers
  //////////////////////////////////////////////////////////////////////

  // Both chains come out of reset disabled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lc_sync1_q  <= LcOff;
      lc_sync2_q  <= LcOff;
      pwr_sync1_q <= LcOff;
      pwr_sync2_q <= LcOff;
    end else begin
      lc_sync1_q  <= lc_cpu_en_i;
      lc_sync2_q  <= lc_sync1_q;
      pwr_sync1_q <= pwr_cpu_en_i;
      pwr_sync2_q <= pwr_sync1_q;
    end
  end

  // Sticky local disable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      local_en_q <= LcOn;
    end else if (fatal_core_err_i) begin
      local_en_q <= LcOff;
    end
  end

  // Strict compare on all three
  assign fetch_enable_o = (lc_sync2_q == LcOn) && (pwr_sync2_q == LcOn) &&
                          (local_en_q == LcOn);

endmodule

`default_nettype wire

/* src/addr_remap.sv */
//////////////////////////////////////////////////////////////////////
// Combinational data-bus remap. Regions are naturally aligned and the
// lowest-indexed enabled hit wins. Valid and ready are not touched.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module addr_remap
  import core_ctrl_pkg::*;
#(
  parameter int NumRegions = 2
) (
  // Core side
  input  logic                   dbus_valid_i,
  input  addr_t                  dbus_addr_i,
  output logic                   dbus_ready_o,
  // Memory side
  output logic                   dbus_valid_o,
  output addr_t                  dbus_addr_o,
  input  logic                   dbus_ready_i,
  // Region configuration
  input  logic [NumRegions-1:0]  region_en_i,
  input  addr_t [NumRegions-1:0] region_match_i,
  input  addr_t [NumRegions-1:0] region_remap_i
);

  addr_t [NumRegions-1:0] dc_mask;
  logic  [NumRegions-1:0] hit;

  // Trailing ones plus the lowest zero of the match word are don't-care
  for (genvar i = 0; i < NumRegions; i++) begin : gen_region
    assign dc_mask[i] = region_match_i[i] ^ (region_match_i[i] + addr_t'(1));
    assign hit[i]     = region_en_i[i] &
                        ((dbus_addr_i & ~dc_mask[i]) == (region_match_i[i] & ~dc_mask[i]));
  end

  // Walk down so that the lowest index is applied last
  always_comb begin
    dbus_addr_o = dbus_addr_i;
    for (int i = NumRegions - 1; i >= 0; i--) begin
      if (hit[i]) begin
        dbus_addr_o = (region_remap_i[i] & ~dc_mask[i]) | (dbus_addr_i & dc_mask[i]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // No storage on this path
  assign dbus_valid_o = dbus_valid_i;
  assign dbus_ready_o = dbus_ready_i;

endmodule

`default_nettype wire

/* src/cfg_regs.sv */
//////////////////////////////////////////////////////////////////////
// Register port without back-pressure. Writes land on the valid edge,
// read data comes back one cycle later with a single rvalid pulse.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cfg_regs
  import core_ctrl_pkg::*;
#(
  parameter int NumRegions = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Register port
  input  logic                       cfg_valid_i,
  input  logic                       cfg_we_i,
  input  cfg_addr_t                  cfg_addr_i,
  input  data_t                      cfg_wdata_i,
  output logic                       cfg_rvalid_o,
  output data_t                      cfg_rdata_o,
  // Watchdog NMI request, asynchronous
  input  logic                       nmi_wdog_i,
  output logic                       irq_nm_o,
  // Remap configuration
  output logic [NumRegions-1:0]      region_en_o,
  output addr_t [NumRegions-1:0]     region_match_o,
  output addr_t [NumRegions-1:0]     region_remap_o,
  // Random word buffer
  input  data_t                      rnd_data_i,
  input  logic                       rnd_valid_i,
  output logic                       rnd_rd_o
);

  function automatic cfg_addr_t match_offset(int unsigned idx);
    return cfg_addr_t'(RegMatchBase + 2 * idx);
  endfunction

  function automatic cfg_addr_t remap_offset(int unsigned idx);
    return cfg_addr_t'(RegRemapBase + 2 * idx);
  endfunction

  logic                   wr_en;
  logic                   rd_en;
  logic [NumRegions-1:0]  region_en_q;
  addr_t [NumRegions-1:0] region_match_q;
  addr_t [NumRegions-1:0] region_remap_q;
  logic                   nmi_enable_q;
  logic                   nmi_state_q;
  logic [1:0]             wdog_sync_q;
  logic                   rvalid_q;
  data_t                  rdata_q;
  data_t                  read_mux;

  assign wr_en = cfg_valid_i & cfg_we_i;
  assign rd_en = cfg_valid_i & ~cfg_we_i;

  //////////////////////////////////////////////////////////////////////
  // Software registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      region_en_q    <= '0;
      region_match_q <= '0;
      region_remap_q <= '0;
      nmi_enable_q   <= 1'b0;
    end else if (wr_en) begin
      if (cfg_addr_i == RegRegionEn) begin
        region_en_q <= cfg_wdata_i[NumRegions-1:0];
      end
      if (cfg_addr_i == RegNmiEnable) begin
        nmi_enable_q <= cfg_wdata_i[0];
      end
      for (int i = 0; i < NumRegions; i++) begin
        if (cfg_addr_i == match_offset(i)) begin
          region_match_q[i] <= cfg_wdata_i;
        end
        if (cfg_addr_i == remap_offset(i)) begin
          region_remap_q[i] <= cfg_wdata_i;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog NMI
  //////////////////////////////////////////////////////////////////////

  // Two-flop synchronizer, then the sticky state bit
  // A new watchdog event beats a software clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wdog_sync_q <= 2'b00;
      nmi_state_q <= 1'b0;
    end else begin
      wdog_sync_q <= {wdog_sync_q[0], nmi_wdog_i};
      if (wdog_sync_q[1]) begin
        nmi_state_q <= 1'b1;
      end else if (wr_en && (cfg_addr_i == RegNmiState) && cfg_wdata_i[0]) begin
        nmi_state_q <= 1'b0;
      end
    end
  end

  assign irq_nm_o = nmi_state_q & nmi_enable_q;

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cfg_addr_i)
      RegRegionEn:  read_mux = data_t'(region_en_q);
      RegNmiEnable: read_mux = data_t'(nmi_enable_q);
      RegNmiState:  read_mux = data_t'(nmi_state_q);
      RegRndData:   read_mux = rnd_data_i;
      RegRndStatus: read_mux = data_t'(rnd_valid_i);
      default:      read_mux = '0;
    endcase
    // Region words sit above the fixed registers
    for (int i = 0; i < NumRegions; i++) begin
      if (cfg_addr_i == match_offset(i)) begin
        read_mux = region_match_q[i];
      end
      if (cfg_addr_i == remap_offset(i)) begin
        read_mux = region_remap_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= read_mux;
    end
  end

  assign cfg_rvalid_o = rvalid_q;
  assign cfg_rdata_o  = rdata_q;

  // Clears the buffer on the same edge that captures the word
  assign rnd_rd_o = rd_en & (cfg_addr_i == RegRndData);

  assign region_en_o    = region_en_q;
  assign region_match_o = region_match_q;
  assign region_remap_o = region_remap_q;

endmodule

`default_nettype wire

/* src/core_ctrl_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Widths, register word offsets and multibit enable codes shared by
// the core control blocks. Offsets assume at most 4 remap regions.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package core_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Bus address on the data side
  typedef logic [31:0] addr_t;

  // Register and entropy word
  typedef logic [31:0] data_t;

  // Word offset on the register port
  typedef logic [3:0] cfg_addr_t;

  // Multibit enable, only LcOn counts as on
  typedef logic [3:0] lc_tx_t;

  localparam lc_tx_t LcOn  = 4'b1010;
  localparam lc_tx_t LcOff = 4'b0101;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // One enable bit per region
  localparam cfg_addr_t RegRegionEn  = 4'd0;
  // Bit 0 enables the watchdog NMI
  localparam cfg_addr_t RegNmiEnable = 4'd1;
  // Bit 0 set by hardware, write 1 to clear
  localparam cfg_addr_t RegNmiState  = 4'd2;
  // Read returns the random word and clears it
  localparam cfg_addr_t RegRndData   = 4'd3;
  // Bit 0 is the random word valid flag
  localparam cfg_addr_t RegRndStatus = 4'd4;
  // Region i match word at 8+2i, remap word at 9+2i
  localparam cfg_addr_t RegMatchBase = 4'd8;
  localparam cfg_addr_t RegRemapBase = 4'd9;

endpackage

`default_nettype wire
